// ==== matmul_top.f ====
rtl/matmul_pkg.sv
rtl/mem_port_pkg.sv
rtl/matmul_controller.sv
rtl/operand_fetcher.sv
rtl/operand_fifo.sv
rtl/dot_product_unit.sv
rtl/result_writer.sv
rtl/matmul_top.sv
tests/matmul_tb.sv

// ==== rtl/dot_product_unit.sv ====
// Signed four-element dot product with registered valid/ready result
`default_nettype none

module dot_product_unit
  import matmul_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic pop_valid_i,
  output logic      pop_ready_o,
  input  wire row_t a_row_i,
  input  wire row_t b_col_i,
  output logic      res_valid_o,
  input  wire logic res_ready_i,
  output result_t   res_data_o
);

  // Four 16-bit products need two extra bits
  typedef logic signed [2*ELEM_WIDTH+1:0] sum_t;

  sum_t    sum;
  logic    res_valid_q;
  result_t res_data_q;
  logic    take;

  // Accept when output register empties this cycle
  assign pop_ready_o = ~res_valid_q || res_ready_i;
  assign take        = pop_valid_i && pop_ready_o;

  // Multiply-accumulate over the tile width
  always_comb begin
    sum = '0;
    for (int k = 0; k < TILE_N; k++) begin
      sum = sum + sum_t'($signed(a_row_i[k]) * $signed(b_col_i[k]));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;    // Result taken, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (take) res_data_q <= result_t'(sum);    // Sign-extended
  end

  assign res_valid_o = res_valid_q;
  assign res_data_o  = res_data_q;

  // Held result must not change under back-pressure
  a_res_hold: assert property (@(posedge clk) disable iff (reset)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_data_o));

endmodule

`default_nettype wire

// ==== rtl/matmul_controller.sv ====
// Instruction register, busy/done state and start pulse of the matmul engine
`default_nettype none

module matmul_controller
  import mem_port_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  instr_valid_i,
  output logic       instr_ready_o,
  input  wire addr_t a_base_i,
  input  wire addr_t b_base_i,
  input  wire addr_t c_base_i,
  input  wire logic  tile_done_i,    // Last C write accepted
  output logic       done_o,
  output logic       start_o,        // One cycle after instruction transfer
  output addr_t      a_base_o,
  output addr_t      b_base_o,
  output addr_t      c_base_o
);

  logic busy_q;
  logic done_q;
  logic start_q;
  logic instr_fire;

  assign instr_fire    = instr_valid_i && instr_ready_o;
  assign instr_ready_o = ~busy_q;    // Single instruction at a time

  // Busy/done state
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= instr_fire;
      if (instr_fire) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;    // Done drops only when new work arrives
      end else if (tile_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Base addresses, held for the whole tile
  always_ff @(posedge clk) begin
    if (instr_fire) begin
      a_base_o <= a_base_i;
      b_base_o <= b_base_i;
      c_base_o <= c_base_i;
    end
  end

  assign done_o  = done_q;
  assign start_o = start_q;

  // Writer must never finish a tile the controller did not start
  a_done_only_when_busy: assert property (@(posedge clk) disable iff (reset)
    tile_done_i |-> busy_q);

endmodule

`default_nettype wire

// ==== rtl/matmul_pkg.sv ====
// Tile geometry, element/row/result types and operand FIFO depth for the matmul engine
`default_nettype none

package matmul_pkg;

  // Element and tile geometry
  localparam int ELEM_WIDTH   = 8;             // One signed matrix element
  localparam int TILE_N       = 4;             // Elements per row or column
  localparam int TILE_ELEMS   = TILE_N * TILE_N; // Results per instruction
  localparam int RESULT_WIDTH = 32;            // One C element

  // Operand pairs buffered between fetcher and dot-product unit
  localparam int FIFO_DEPTH = 4;

  typedef logic signed [ELEM_WIDTH-1:0] elem_t;

  // Element 0 sits in the low bits, same layout for A rows and B columns
  typedef elem_t [TILE_N-1:0] row_t;

  typedef logic signed [RESULT_WIDTH-1:0] result_t;

  // Counts 0..TILE_ELEMS inclusive
  typedef logic [$clog2(TILE_ELEMS+1)-1:0] tile_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/matmul_top.sv ====
// Top level: controller, operand fetcher, operand FIFO, dot-product unit and result writer
`default_nettype none

module matmul_top
  import matmul_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  // Instruction channel
  input  wire logic    instr_valid_i,
  output logic         instr_ready_o,
  input  wire addr_t   a_base_i,
  input  wire addr_t   b_base_i,
  input  wire addr_t   c_base_i,
  output logic         done_o,
  // A and B read ports, one cycle latency
  output logic         rd_a_en_o,
  output addr_t        rd_a_addr_o,
  input  wire row_t    rd_a_data_i,
  output logic         rd_b_en_o,
  output addr_t        rd_b_addr_o,
  input  wire row_t    rd_b_data_i,
  // C write port
  output logic         wr_valid_o,
  input  wire logic    wr_ready_i,
  output addr_t        wr_addr_o,
  output result_t      wr_data_o
);

  logic    start;
  logic    tile_done;
  addr_t   a_base;
  addr_t   b_base;
  addr_t   c_base;
  logic    push_valid;
  logic    push_ready;
  row_t    push_a;
  row_t    push_b;
  logic    pop_valid;
  logic    pop_ready;
  row_t    pop_a;
  row_t    pop_b;
  logic    res_valid;
  logic    res_ready;
  result_t res_data;

  matmul_controller controller_inst (
    .clk, .reset, .instr_valid_i, .instr_ready_o, .a_base_i, .b_base_i, .c_base_i,
    .tile_done_i(tile_done), .done_o, .start_o(start),
    .a_base_o(a_base), .b_base_o(b_base), .c_base_o(c_base)
  );

  // Producer
  operand_fetcher fetcher_inst (
    .clk, .reset, .start_i(start), .a_base_i(a_base), .b_base_i(b_base),
    .rd_a_en_o, .rd_a_addr_o, .rd_a_data_i, .rd_b_en_o, .rd_b_addr_o, .rd_b_data_i,
    .push_valid_o(push_valid), .push_ready_i(push_ready),
    .push_a_o(push_a), .push_b_o(push_b)
  );

  operand_fifo fifo_inst (
    .clk, .reset, .push_valid_i(push_valid), .push_ready_o(push_ready),
    .push_a_i(push_a), .push_b_i(push_b), .pop_valid_o(pop_valid),
    .pop_ready_i(pop_ready), .pop_a_o(pop_a), .pop_b_o(pop_b)
  );

  // Consumer, compute then write
  dot_product_unit dot_inst (
    .clk, .reset, .pop_valid_i(pop_valid), .pop_ready_o(pop_ready),
    .a_row_i(pop_a), .b_col_i(pop_b), .res_valid_o(res_valid),
    .res_ready_i(res_ready), .res_data_o(res_data)
  );

  result_writer writer_inst (
    .clk, .reset, .start_i(start), .c_base_i(c_base),
    .res_valid_i(res_valid), .res_ready_o(res_ready), .res_data_i(res_data),
    .wr_valid_o, .wr_ready_i, .wr_addr_o, .wr_data_o, .tile_done_o(tile_done)
  );

endmodule

`default_nettype wire

// ==== rtl/mem_port_pkg.sv ====
// Memory address/word widths, address type and read latency of the memory ports
`default_nettype none

package mem_port_pkg;

  localparam int ADDR_WIDTH     = 16;   // Word address
  localparam int MEM_WORD_WIDTH = 32;   // One read word, holds a full row or column
  localparam int READ_LATENCY   = 1;    // Cycles from enable to data

  typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

// ==== rtl/operand_fetcher.sv ====
// Operand fetcher walking (i, j) over the tile, paired A/B read issue and push of returned pairs
`default_nettype none

module operand_fetcher
  import matmul_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  start_i,        // Begin a new tile
  input  wire addr_t a_base_i,
  input  wire addr_t b_base_i,
  output logic       rd_a_en_o,
  output addr_t      rd_a_addr_o,
  input  wire row_t  rd_a_data_i,
  output logic       rd_b_en_o,
  output addr_t      rd_b_addr_o,
  input  wire row_t  rd_b_data_i,
  output logic       push_valid_o,
  input  wire logic  push_ready_i,
  output row_t       push_a_o,
  output row_t       push_b_o
);

  typedef logic [$clog2(TILE_N)-1:0] idx_t;

  idx_t                    i_q;        // A row index
  idx_t                    j_q;        // B column index that runs fastest
  logic                    active_q;   // Pairs still to issue
  logic [READ_LATENCY-1:0] pend_q;     // Reads on their way back
  logic                    issue;
  logic [MEM_WORD_WIDTH-1:0] a_word;   // Raw memory words
  logic [MEM_WORD_WIDTH-1:0] b_word;

  // At most one pair in flight and FIFO space checked at issue time
  assign issue = active_q && push_ready_i && ~|pend_q;

  assign rd_a_en_o   = issue;
  assign rd_b_en_o   = issue;
  assign rd_a_addr_o = a_base_i + addr_t'(i_q);   // Word i of A holds row i
  assign rd_b_addr_o = b_base_i + addr_t'(j_q);   // Word j of B holds column j

  always_ff @(posedge clk) begin
    if (reset) begin
      active_q <= 1'b0;
      pend_q   <= '0;
      i_q      <= '0;
      j_q      <= '0;
    end else begin
      pend_q <= READ_LATENCY'({pend_q, issue});    // Shift along the read latency
      if (start_i) begin
        active_q <= 1'b1;
        i_q      <= '0;
        j_q      <= '0;
      end else if (issue) begin
        if (j_q == idx_t'(TILE_N - 1)) begin
          j_q <= '0;
          if (i_q == idx_t'(TILE_N - 1)) active_q <= 1'b0;    // Last pair issued
          else i_q <= i_q + 1'b1;
        end else begin
          j_q <= j_q + 1'b1;
        end
      end
    end
  end

  // Returned data goes straight into the FIFO
  assign a_word       = rd_a_data_i;
  assign b_word       = rd_b_data_i;
  assign push_valid_o = pend_q[READ_LATENCY-1];
  assign push_a_o     = a_word;
  assign push_b_o     = b_word;

  // Space reserved at issue must still be there on return
  a_push_has_space: assert property (@(posedge clk) disable iff (reset)
    push_valid_o |-> push_ready_i);

endmodule

`default_nettype wire

// ==== rtl/operand_fifo.sv ====
// Operand FIFO of A-row/B-column pairs with valid/ready on push and pop sides
`default_nettype none

module operand_fifo
  import matmul_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic push_valid_i,
  output logic      push_ready_o,
  input  wire row_t push_a_i,
  input  wire row_t push_b_i,
  output logic      pop_valid_o,
  input  wire logic pop_ready_i,
  output row_t      pop_a_o,
  output row_t      pop_b_o
);

  typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

  row_t mem_a [FIFO_DEPTH];    // A rows
  row_t mem_b [FIFO_DEPTH];    // B columns in the same slot as their row
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic push;
  logic pop;

  assign push_ready_o = (count_q != cnt_t'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;

  // Pair storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_a[wr_ptr_q] <= push_a_i;
      mem_b[wr_ptr_q] <= push_b_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;    // Both or neither
      endcase
    end
  end

  assign pop_a_o = mem_a[rd_ptr_q];
  assign pop_b_o = mem_b[rd_ptr_q];

  // Producer must never push into a full FIFO
  a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    push_valid_i |-> (count_q != cnt_t'(FIFO_DEPTH)));

endmodule

`default_nettype wire

// ==== rtl/result_writer.sv ====
// Result writer: C address generation, memory write handshake and write counting
`default_nettype none

module result_writer
  import matmul_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    start_i,      // Clears the write count
  input  wire addr_t   c_base_i,
  input  wire logic    res_valid_i,
  output logic         res_ready_o,
  input  wire result_t res_data_i,
  output logic         wr_valid_o,
  input  wire logic    wr_ready_i,
  output addr_t        wr_addr_o,
  output result_t      wr_data_o,
  output logic         tile_done_o   // High on the 16th write transfer
);

  tile_cnt_t cnt_q;       // Completed writes, also the row-major C offset
  logic      wr_valid_q;
  result_t   wr_data_q;
  logic      wr_fire;

  assign wr_fire     = wr_valid_q && wr_ready_i;
  assign res_ready_o = ~wr_valid_q || wr_ready_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      if (res_valid_i && res_ready_o) wr_valid_q <= 1'b1;
      else if (wr_ready_i)            wr_valid_q <= 1'b0;
      if (start_i)      cnt_q <= '0;
      else if (wr_fire) cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i && res_ready_o) wr_data_q <= res_data_i;
  end

  // C[i][j] lands at c_base + 4i + j, i.e. base plus write index
  assign wr_addr_o   = c_base_i + addr_t'(cnt_q);
  assign wr_data_o   = wr_data_q;
  assign wr_valid_o  = wr_valid_q;
  assign tile_done_o = wr_fire && (cnt_q == tile_cnt_t'(TILE_ELEMS - 1));

  // Write request holds while memory stalls
  a_wr_hold: assert property (@(posedge clk) disable iff (reset)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_addr_o) && $stable(wr_data_o));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f matmul_top.f \
  --top-module matmul_tb --Mdir obj_dir -o matmul_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/matmul_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tests/matmul_tb.sv ====
// Testbench for matmul_top with clock, reset, memory model, stimulus table, reference model and checks
`default_nettype none

module matmul_tb
  import matmul_pkg::*;
  import mem_port_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 6;
  localparam int MEM_WORDS = 64;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 300 + 4;    // Per table row plus reset
  localparam logic [1:0] FILL_RAND = 2'd0, FILL_EXTREME = 2'd1, FILL_NEG = 2'd2;

  typedef struct packed {
    addr_t       a_base;
    addr_t       b_base;
    addr_t       c_base;
    logic [1:0]  fill;        // Random, -128/127 mix or all -128
    logic [7:0]  stall_pct;   // Chance of wr_ready_i low per cycle
    logic        early;       // Present while previous tile runs
  } stim_t;

  // A/B regions never overlap so all fills happen before reset
  localparam stim_t STIM [NUM_TESTS] = '{
    '{16'd0,  16'd4,  16'd0,   FILL_RAND,    8'd0,  1'b0},
    '{16'd8,  16'd12, 16'd16,  FILL_RAND,    8'd40, 1'b0},
    '{16'd16, 16'd20, 16'd32,  FILL_EXTREME, 8'd25, 1'b1},
    '{16'd24, 16'd28, 16'd48,  FILL_NEG,     8'd0,  1'b1},
    '{16'd32, 16'd36, 16'd16,  FILL_RAND,    8'd60, 1'b0},
    '{16'd40, 16'd44, 16'd200, FILL_EXTREME, 8'd10, 1'b1}};

  logic clk, reset, instr_valid_i, instr_ready_o, done_o;
  addr_t a_base_i, b_base_i, c_base_i, rd_a_addr_o, rd_b_addr_o, wr_addr_o;
  logic rd_a_en_o, rd_b_en_o, wr_valid_o, wr_ready_i;
  row_t rd_a_data_i, rd_b_data_i;
  result_t wr_data_o;

  logic [31:0] mem [MEM_WORDS];    // A rows and B columns
  int exp_tab [NUM_TESTS][TILE_ELEMS];
  int cur_test = -1, write_idx = 0, stall_now = 0, finished = 0, cycle_cnt = 0;
  int err_count = 0, test_errs = 0, tests_failed = 0, read_idx = 0;
  addr_t cur_c_base, held_addr;
  result_t held_data;
  logic in_flight = 1'b0, hold_pend = 1'b0;
  logic written [256];             // C addresses hit by the running test

  matmul_top matmul_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] make_word(logic [1:0] fill);
    logic [31:0] word;
    word = $urandom;
    if (fill == FILL_NEG) word = 32'h8080_8080;    // -128 everywhere
    else if (fill == FILL_EXTREME)
      for (int k = 0; k < 4; k++) word[8*k +: 8] = word[8*k] ? 8'h80 : 8'h7f;
    return word;
  endfunction

  // Sum of signed byte products with byte 0 in the low bits
  function automatic int dot_ref(logic [31:0] a_word, logic [31:0] b_word);
    int acc;
    acc = 0;
    for (int k = 0; k < 4; k++) acc += $signed(a_word[8*k +: 8]) * $signed(b_word[8*k +: 8]);
    return acc;
  endfunction

  task automatic report_mismatch(string sig, longint expected, longint actual);
    $display("CHECK FAILED at %0d ns: %s expected %0d, got %0d", $time, sig, expected, actual);
    err_count++;
    test_errs++;
  endtask

  task automatic report_problem(string what);
    $display("ERROR at %0d ns: %s", $time, what);
    err_count++;
    test_errs++;
  endtask

  task automatic issue_instr(int t);
    a_base_i      <= STIM[t].a_base;
    b_base_i      <= STIM[t].b_base;
    c_base_i      <= STIM[t].c_base;
    instr_valid_i <= 1'b1;
    @(posedge clk);
    while (!instr_ready_o) @(posedge clk);    // Held until the engine takes it
    instr_valid_i <= 1'b0;
  endtask

  initial begin
    {reset, instr_valid_i, wr_ready_i} = 3'b100;
    {a_base_i, b_base_i, c_base_i} = '0;
    {rd_a_data_i, rd_b_data_i} = '0;
    void'($urandom(32'hfa7816f0));
    for (int w = 0; w < MEM_WORDS; w++) mem[w] = 32'h0101_0101 * w;    // Background
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int w = 0; w < TILE_N; w++) mem[STIM[t].a_base + w] = make_word(STIM[t].fill);
      for (int w = 0; w < TILE_N; w++) mem[STIM[t].b_base + w] = make_word(STIM[t].fill);
      for (int e = 0; e < TILE_ELEMS; e++)
        exp_tab[t][e] = dot_ref(mem[STIM[t].a_base + e / 4], mem[STIM[t].b_base + e % 4]);
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);    // Idle cycles for the reset state checks
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (STIM[t].early) repeat (5) @(posedge clk);    // Previous tile still busy
      else begin
        while (finished < t) @(posedge clk);
        repeat (3) @(posedge clk);
      end
      issue_instr(t);
    end
    while (finished < NUM_TESTS) @(posedge clk);
    @(negedge clk);
    $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, tests_failed, err_count);
    if (err_count == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

  // Memory model with one-cycle read latency on both ports
  always @(posedge clk) begin
    if (rd_a_en_o) rd_a_data_i <= mem[rd_a_addr_o[5:0]];
    if (rd_b_en_o) rd_b_data_i <= mem[rd_b_addr_o[5:0]];
  end

  // Write port, read address, handshake and done monitor
  always @(posedge clk) begin
    if (!reset) begin
      wr_ready_i <= (($urandom % 100) >= stall_now);
      if (hold_pend && !wr_valid_o) report_problem("wr_valid_o dropped before wr_ready_i");
      if (hold_pend && wr_addr_o != held_addr) report_mismatch("wr_addr_o", held_addr, wr_addr_o);
      if (hold_pend && wr_data_o != held_data) report_mismatch("wr_data_o", held_data, wr_data_o);
      hold_pend = wr_valid_o && !wr_ready_i;
      held_addr = wr_addr_o;
      held_data = wr_data_o;
      if (in_flight && (rd_a_en_o || rd_b_en_o)) begin    // Row-major walk, j fastest
        if (rd_a_en_o != rd_b_en_o) report_problem("A and B reads not issued together");
        if (rd_a_addr_o != STIM[cur_test].a_base + addr_t'(read_idx / TILE_N))
          report_mismatch("rd_a_addr_o", STIM[cur_test].a_base + read_idx / TILE_N, rd_a_addr_o);
        if (rd_b_addr_o != STIM[cur_test].b_base + addr_t'(read_idx % TILE_N))
          report_mismatch("rd_b_addr_o", STIM[cur_test].b_base + read_idx % TILE_N, rd_b_addr_o);
        read_idx++;
      end
      if (wr_valid_o && wr_ready_i && in_flight) begin
        if (wr_addr_o != cur_c_base + addr_t'(write_idx))
          report_mismatch("wr_addr_o", cur_c_base + write_idx, wr_addr_o);
        if (wr_addr_o - cur_c_base >= addr_t'(TILE_ELEMS)) report_problem("write outside C region");
        if (written[wr_addr_o[7:0]]) report_problem("C address written twice");
        written[wr_addr_o[7:0]] = 1'b1;
        if (write_idx < TILE_ELEMS && wr_data_o != exp_tab[cur_test][write_idx])
          report_mismatch("wr_data_o", exp_tab[cur_test][write_idx], wr_data_o);
        write_idx++;
      end
      if (in_flight && done_o) begin    // Tile finished
        if (write_idx != TILE_ELEMS) report_mismatch("writes at done_o", TILE_ELEMS, write_idx);
        if (read_idx != TILE_ELEMS) report_mismatch("reads at done_o", TILE_ELEMS, read_idx);
        if (test_errs != 0) tests_failed++;
        $display("test %0d: %0d writes, %0d errors", cur_test, write_idx, test_errs);
        in_flight = 1'b0;
        finished <= finished + 1;
      end
      if (instr_valid_i && instr_ready_o) begin
        if (in_flight) report_problem("instruction accepted while busy");
        cur_test++;
        cur_c_base = c_base_i;
        stall_now  = STIM[cur_test].stall_pct;
        {write_idx, read_idx, test_errs} = '0;
        foreach (written[k]) written[k] = 1'b0;
        in_flight = 1'b1;
      end else if (in_flight) begin
        if (instr_ready_o) report_problem("instr_ready_o high while busy");
      end else begin
        if (cur_test < 0 && !instr_ready_o) report_mismatch("instr_ready_o", 1, instr_ready_o);
        if (cur_test < 0 && done_o) report_mismatch("done_o", 0, done_o);
        if (cur_test >= 0 && !done_o) report_problem("done_o dropped before next instruction");
        if (rd_a_en_o || rd_b_en_o || wr_valid_o) report_problem("memory port active while idle");
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the DUT did not finish", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire
